//--- Bender.yml
package:
  name: ex_unit

sources:
  - files:
      - src/core_pkg.sv
      - src/ex_issue_if.sv
      - src/alu.sv
      - src/cmp.sv
      - src/ex_reg.sv
      - src/ex_stage.sv
      - src/ex_unit_top.sv
  - target: test
    files:
      - verification/ex_clk_gen.sv
      - verification/ex_unit_tb.sv

//--- sources.f
src/core_pkg.sv
src/ex_issue_if.sv
src/alu.sv
src/cmp.sv
src/ex_reg.sv
src/ex_stage.sv
src/ex_unit_top.sv
verification/ex_clk_gen.sv
verification/ex_unit_tb.sv

//--- src/alu.sv
// Integer ALU
// Add, subtract, logic, shifts, set-less-than and operand pass.
// Also forms branch and jump targets through ALU_ADD.
// Purely combinational

`timescale 1ns/1ps

module alu import core_pkg::*; #(
    parameter int DATA_W = word_w
) (
    input  logic [DATA_W-1:0] arg0,
    input  logic [DATA_W-1:0] arg1,
    input  alu_op_e           op,
    output logic [DATA_W-1:0] val
);

    localparam int sh_w = $clog2(DATA_W); // 5 bits at 32

    logic [sh_w-1:0] shamt;
    logic            lt_s;  // Signed less than
    logic            lt_u;  // Unsigned less than

    assign shamt = arg1[sh_w-1:0]; // Upper bits ignored
    assign lt_s  = $signed(arg0) < $signed(arg1);
    assign lt_u  = arg0 < arg1;

    //////////////////////////////
    // Operation select
    //////////////////////////////
    always_comb begin
        case (op)
            ALU_ADD:   val = arg0 + arg1;
            ALU_SUB:   val = arg0 - arg1;
            ALU_AND:   val = arg0 & arg1;
            ALU_OR:    val = arg0 | arg1;
            ALU_XOR:   val = arg0 ^ arg1;
            ALU_SLL:   val = arg0 << shamt;
            ALU_SRL:   val = arg0 >> shamt;
            // Arithmetic shift keeps the sign bit
            ALU_SRA:   val = $unsigned($signed(arg0) >>> shamt);
            ALU_SLT:   val = {{(DATA_W-1){1'b0}}, lt_s}; // 1 or 0
            ALU_SLTU:  val = {{(DATA_W-1){1'b0}}, lt_u};
            ALU_PASS1: val = arg1;                       // LUI
            default:   val = '0;                         // Undefined op
        endcase
    end

endmodule

//--- src/cmp.sv
// Branch comparator
// Evaluates equality and signed or unsigned order of two operands
// for conditional branches. Combinational, one hit bit out

`timescale 1ns/1ps

module cmp import core_pkg::*; #(
    parameter int DATA_W = word_w
) (
    input  logic [DATA_W-1:0] arg0,
    input  logic [DATA_W-1:0] arg1,
    input  cmp_op_e           op,
    output logic              hit
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = arg0 == arg1;
    assign lt_s = $signed(arg0) < $signed(arg1);
    assign lt_u = arg0 < arg1;

    always_comb begin
        case (op)
            CMP_EQ:  hit = eq;
            CMP_NE:  hit = !eq;
            CMP_LT:  hit = lt_s;
            CMP_GE:  hit = !lt_s;  // Greater or equal, signed
            CMP_LTU: hit = lt_u;
            CMP_GEU: hit = !lt_u;
            default: hit = 1'b0;   // Never taken
        endcase
    end

endmodule

//--- src/core_pkg.sv
// Core package for the integer pipeline
// Holds the datapath widths and the operation codes seen by the
// execute stage: ALU ops, branch compare ops, memory ops and the
// result select of the EX stage

package core_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////
    localparam int word_w     = 32; // Data and PC width
    localparam int reg_addr_w = 5;  // GPR index
    localparam int exp_code_w = 3;  // Exception code, carried only

    //////////////////////////////
    // ALU operation codes
    //////////////////////////////
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,  // Also branch and jump targets
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLL   = 4'd5,  // Shift amount from low bits of arg1
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_SLT   = 4'd8,  // Signed set less than, 1 or 0
        ALU_SLTU  = 4'd9,  // Unsigned set less than
        ALU_PASS1 = 4'd10  // Second operand through, for LUI
    } alu_op_e;

    //////////////////////////////
    // Branch compare codes
    //////////////////////////////
    typedef enum logic [2:0] {
        CMP_EQ  = 3'd0,
        CMP_NE  = 3'd1,
        CMP_LT  = 3'd2, // Signed
        CMP_GE  = 3'd3,
        CMP_LTU = 3'd4, // Unsigned
        CMP_GEU = 3'd5
    } cmp_op_e;

    // Memory access codes, decoded in MEM
    typedef enum logic [3:0] {
        MEM_NOP = 4'd0, // Bubble value
        MEM_LB  = 4'd1,
        MEM_LH  = 4'd2,
        MEM_LW  = 4'd3,
        MEM_LBU = 4'd4,
        MEM_LHU = 4'd5,
        MEM_SB  = 4'd6,
        MEM_SH  = 4'd7,
        MEM_SW  = 4'd8
    } mem_op_e;

    // EX result select
    typedef enum logic [1:0] {
        EX_OUT_ALU = 2'd0, // ALU result
        EX_OUT_CMP = 2'd1, // Compare bit, zero extended
        EX_OUT_PCN = 2'd2, // Link value, PC plus four
        EX_OUT_RSV = 2'd3  // Reserved, gives zero
    } ex_out_sel_e;

endpackage

//--- src/ex_issue_if.sv
// ID/EX issue bundle
// Carries one decoded instruction per cycle into the execute stage.
// The src side is the ID/EX boundary, dst is the execute stage.

`timescale 1ns/1ps

interface ex_issue_if import core_pkg::*; #(
    parameter int DATA_W = word_w
) ();

    logic                  is_jalr;     // JALR, target LSB cleared
    logic [exp_code_w-1:0] exp_code;    // Passed to MEM untouched
    logic [DATA_W-1:0]     pc;
    logic                  en;          // Valid instruction
    alu_op_e               alu_op;
    logic [DATA_W-1:0]     alu_in_0;
    logic [DATA_W-1:0]     alu_in_1;    // Immediate for stores
    cmp_op_e               cmp_op;
    logic [DATA_W-1:0]     cmp_in_0;
    logic [DATA_W-1:0]     cmp_in_1;
    logic                  jump_taken;  // Unconditional jump
    mem_op_e               mem_op;
    logic [DATA_W-1:0]     mem_wr_data; // Store data, rs2
    logic [reg_addr_w-1:0] rd_addr;
    logic                  gpr_we_n;    // Active low GPR write
    ex_out_sel_e           ex_out_sel;
    logic [DATA_W-1:0]     gpr_wr_data; // PC plus four from ID

    // Issuing side
    modport src (
        output is_jalr, exp_code, pc, en,
        output alu_op, alu_in_0, alu_in_1,
        output cmp_op, cmp_in_0, cmp_in_1, jump_taken,
        output mem_op, mem_wr_data, rd_addr, gpr_we_n,
        output ex_out_sel, gpr_wr_data
    );

    // Execute stage side
    modport dst (
        input is_jalr, exp_code, pc, en,
        input alu_op, alu_in_0, alu_in_1,
        input cmp_op, cmp_in_0, cmp_in_1, jump_taken,
        input mem_op, mem_wr_data, rd_addr, gpr_we_n,
        input ex_out_sel, gpr_wr_data
    );

endinterface

//--- src/ex_reg.sv
// EX/MEM pipeline register
// Loads the execute result and the pass-through fields each cycle.
// Stall holds everything, flush loads a bubble. Reset wins over
// both, stall wins over flush

`timescale 1ns/1ps

module ex_reg import core_pkg::*; #(
    parameter int DATA_W = word_w
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,          // Hold all fields
    input  logic                  flush,          // Insert bubble
    // From execute logic
    input  logic [exp_code_w-1:0] in_exp_code,
    input  logic [DATA_W-1:0]     in_pc,
    input  logic                  in_en,
    input  mem_op_e               in_mem_op,
    input  logic [DATA_W-1:0]     in_mem_wr_data, // After forwarding
    input  logic [reg_addr_w-1:0] in_rd_addr,
    input  logic                  in_gpr_we_n,
    input  logic [DATA_W-1:0]     in_out,         // Selected result
    // To MEM stage
    output logic [exp_code_w-1:0] ex_exp_code,
    output logic [DATA_W-1:0]     ex_pc,
    output logic                  ex_en,
    output mem_op_e               ex_mem_op,
    output logic [DATA_W-1:0]     ex_mem_wr_data,
    output logic [reg_addr_w-1:0] ex_rd_addr,
    output logic                  ex_gpr_we_n,
    output logic [DATA_W-1:0]     ex_out
);

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_en          <= 1'b0;   // No instruction
            ex_gpr_we_n    <= 1'b1;   // No GPR write
            ex_mem_op      <= MEM_NOP;
            ex_exp_code    <= '0;
            ex_pc          <= '0;
            ex_mem_wr_data <= '0;
            ex_rd_addr     <= '0;
            ex_out         <= '0;
        end else if (!stall) begin    // Stall keeps old contents
            if (flush) begin
                // Bubble, data fields zeroed
                ex_en          <= 1'b0;
                ex_gpr_we_n    <= 1'b1;
                ex_mem_op      <= MEM_NOP;
                ex_exp_code    <= '0;
                ex_pc          <= '0;
                ex_mem_wr_data <= '0;
                ex_rd_addr     <= '0;
                ex_out         <= '0;
            end else begin
                ex_en          <= in_en;
                ex_gpr_we_n    <= in_gpr_we_n;
                ex_mem_op      <= in_mem_op;
                ex_exp_code    <= in_exp_code;
                ex_pc          <= in_pc;
                ex_mem_wr_data <= in_mem_wr_data;
                ex_rd_addr     <= in_rd_addr;
                ex_out         <= in_out;
            end
        end
    end

endmodule

//--- src/ex_stage.sv
// Execute stage
// Forwards load data from MEM, runs the ALU and the branch
// comparator, selects the stage result and resolves branches.
// Ends in the EX/MEM pipeline register

`timescale 1ns/1ps

module ex_stage import core_pkg::*; #(
    parameter int DATA_W = word_w
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  logic                  flush,
    ex_issue_if.dst               issue,          // ID/EX fields
    // Forwarding from MEM
    input  logic                  rs1_fwd_en,
    input  logic                  rs2_fwd_en,
    input  logic [DATA_W-1:0]     mem_fwd_data,   // Load result
    // Same-cycle outputs
    output logic [DATA_W-1:0]     fwd_data,       // To ID bypass
    output logic [DATA_W-1:0]     br_addr,        // Target PC to IF
    output logic                  br_taken,
    // EX/MEM register
    output logic [exp_code_w-1:0] ex_exp_code,
    output logic [DATA_W-1:0]     ex_pc,
    output logic                  ex_en,
    output mem_op_e               ex_mem_op,
    output logic [DATA_W-1:0]     ex_mem_wr_data,
    output logic [reg_addr_w-1:0] ex_rd_addr,
    output logic                  ex_gpr_we_n,
    output logic [DATA_W-1:0]     ex_out
);

    logic [DATA_W-1:0] alu_in_0;    // After rs1 forwarding
    logic [DATA_W-1:0] mem_wr_data; // After rs2 forwarding
    logic [DATA_W-1:0] alu_out;
    logic              cmp_hit;
    logic [DATA_W-1:0] out_data;    // Selected stage result

    //////////////////////////////
    // Forwarding
    //////////////////////////////
    // Load in MEM feeding this instruction. Operand 1 stays as is,
    // it carries the offset for stores
    assign alu_in_0    = rs1_fwd_en ? mem_fwd_data : issue.alu_in_0;
    assign mem_wr_data = rs2_fwd_en ? mem_fwd_data : issue.mem_wr_data;

    alu #(.DATA_W(DATA_W)) u_alu (
        .arg0 (alu_in_0),
        .arg1 (issue.alu_in_1),
        .op   (issue.alu_op),
        .val  (alu_out)
    );

    cmp #(.DATA_W(DATA_W)) u_cmp (
        .arg0 (issue.cmp_in_0),
        .arg1 (issue.cmp_in_1),
        .op   (issue.cmp_op),
        .hit  (cmp_hit)
    );

    //////////////////////////////
    // Result select
    //////////////////////////////
    always_comb begin
        case (issue.ex_out_sel)
            EX_OUT_ALU: out_data = alu_out;
            EX_OUT_CMP: out_data = {{(DATA_W-1){1'b0}}, cmp_hit};
            EX_OUT_PCN: out_data = issue.gpr_wr_data; // Link address
            default:    out_data = '0;
        endcase
    end

    assign fwd_data = out_data; // Bypass to ID, same cycle

    // Branch resolution
    assign br_addr  = issue.is_jalr ? {alu_out[DATA_W-1:1], 1'b0} : alu_out;
    // Conditional branches write no GPR, so gpr_we_n is 1 for them
    assign br_taken = (cmp_hit && issue.gpr_we_n) || issue.jump_taken;

    ex_reg #(.DATA_W(DATA_W)) u_ex_reg (
        .clk            (clk),
        .rst            (rst),
        .stall          (stall),
        .flush          (flush),
        .in_exp_code    (issue.exp_code),
        .in_pc          (issue.pc),
        .in_en          (issue.en),
        .in_mem_op      (issue.mem_op),
        .in_mem_wr_data (mem_wr_data),     // Forwarded store data
        .in_rd_addr     (issue.rd_addr),
        .in_gpr_we_n    (issue.gpr_we_n),
        .in_out         (out_data),
        .ex_exp_code    (ex_exp_code),
        .ex_pc          (ex_pc),
        .ex_en          (ex_en),
        .ex_mem_op      (ex_mem_op),
        .ex_mem_wr_data (ex_mem_wr_data),
        .ex_rd_addr     (ex_rd_addr),
        .ex_gpr_we_n    (ex_gpr_we_n),
        .ex_out         (ex_out)
    );

endmodule

//--- src/ex_unit_top.sv
// Execute unit top level
// Plain ID/EX ports are gathered onto the issue interface
// and fed to the execute stage with its EX/MEM register

`timescale 1ns/1ps

module ex_unit_top import core_pkg::*; #(
    parameter int DATA_W = word_w
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  logic                  flush,
    // ID/EX fields
    input  logic                  id_is_jalr,
    input  logic [exp_code_w-1:0] id_exp_code,
    input  logic [DATA_W-1:0]     id_pc,
    input  logic                  id_en,
    input  alu_op_e               id_alu_op,
    input  logic [DATA_W-1:0]     id_alu_in_0,
    input  logic [DATA_W-1:0]     id_alu_in_1,
    input  cmp_op_e               id_cmp_op,
    input  logic [DATA_W-1:0]     id_cmp_in_0,
    input  logic [DATA_W-1:0]     id_cmp_in_1,
    input  logic                  id_jump_taken,
    input  mem_op_e               id_mem_op,
    input  logic [DATA_W-1:0]     id_mem_wr_data,
    input  logic [reg_addr_w-1:0] id_rd_addr,
    input  logic                  id_gpr_we_n,
    input  ex_out_sel_e           id_ex_out_sel,
    input  logic [DATA_W-1:0]     id_gpr_wr_data,
    // Forwarding
    input  logic                  rs1_fwd_en,
    input  logic                  rs2_fwd_en,
    input  logic [DATA_W-1:0]     mem_fwd_data,
    // Combinational
    output logic [DATA_W-1:0]     fwd_data,
    output logic [DATA_W-1:0]     br_addr,
    output logic                  br_taken,
    // Registered, to MEM
    output logic [exp_code_w-1:0] ex_exp_code,
    output logic [DATA_W-1:0]     ex_pc,
    output logic                  ex_en,
    output mem_op_e               ex_mem_op,
    output logic [DATA_W-1:0]     ex_mem_wr_data,
    output logic [reg_addr_w-1:0] ex_rd_addr,
    output logic                  ex_gpr_we_n,
    output logic [DATA_W-1:0]     ex_out
);

    ex_issue_if #(.DATA_W(DATA_W)) issue_if ();

    //////////////////////////////
    // Port to interface mapping
    //////////////////////////////
    assign issue_if.is_jalr     = id_is_jalr;
    assign issue_if.exp_code    = id_exp_code;
    assign issue_if.pc          = id_pc;
    assign issue_if.en          = id_en;
    assign issue_if.alu_op      = id_alu_op;
    assign issue_if.alu_in_0    = id_alu_in_0;
    assign issue_if.alu_in_1    = id_alu_in_1;
    assign issue_if.cmp_op      = id_cmp_op;
    assign issue_if.cmp_in_0    = id_cmp_in_0;
    assign issue_if.cmp_in_1    = id_cmp_in_1;
    assign issue_if.jump_taken  = id_jump_taken;
    assign issue_if.mem_op      = id_mem_op;
    assign issue_if.mem_wr_data = id_mem_wr_data;
    assign issue_if.rd_addr     = id_rd_addr;
    assign issue_if.gpr_we_n    = id_gpr_we_n;
    assign issue_if.ex_out_sel  = id_ex_out_sel;
    assign issue_if.gpr_wr_data = id_gpr_wr_data; // PC plus four

    ex_stage #(.DATA_W(DATA_W)) u_ex_stage (
        .clk            (clk),
        .rst            (rst),
        .stall          (stall),
        .flush          (flush),
        .issue          (issue_if.dst),
        .rs1_fwd_en     (rs1_fwd_en),
        .rs2_fwd_en     (rs2_fwd_en),
        .mem_fwd_data   (mem_fwd_data),
        .fwd_data       (fwd_data),
        .br_addr        (br_addr),
        .br_taken       (br_taken),
        .ex_exp_code    (ex_exp_code),
        .ex_pc          (ex_pc),
        .ex_en          (ex_en),
        .ex_mem_op      (ex_mem_op),
        .ex_mem_wr_data (ex_mem_wr_data),
        .ex_rd_addr     (ex_rd_addr),
        .ex_gpr_we_n    (ex_gpr_we_n),
        .ex_out         (ex_out)
    );

endmodule

//--- verification/ex_clk_gen.sv
// Testbench clock and reset
// Free-running clock, reset held high for the first cycles

`timescale 1ns/1ps

module ex_clk_gen #(
    parameter int period_ns  = 10,
    parameter int rst_cycles = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        @(negedge clk);     // Release away from the active edge
        rst = 1'b0;
    end

endmodule

//--- verification/ex_unit_tb.sv
// Testbench for the execute unit
// Directed table rows, stall and flush sequence, then random ALU
// traffic checked against a reference model of the ALU rules

`timescale 1ns/1ps

module ex_unit_tb import core_pkg::*; ();

    localparam int n_rows     = 25;
    localparam int n_rand     = 200;
    localparam int max_cycles = n_rows + n_rand + 50;
    localparam logic [word_w-1:0] fwd_val = 32'h0000_1000; // Load data in MEM

    // One instruction with its expected responses
    typedef struct packed {
        alu_op_e               op;
        logic [word_w-1:0]     a0;
        logic [word_w-1:0]     a1;
        cmp_op_e               cop;
        logic [word_w-1:0]     c0;
        logic [word_w-1:0]     c1;
        logic                  jalr;
        logic                  jump;
        logic                  we_n;
        ex_out_sel_e           sel;
        logic [word_w-1:0]     link;       // PC plus four
        logic                  f1;         // rs1 forward
        logic                  f2;         // rs2 forward
        logic [word_w-1:0]     pc;
        logic [word_w-1:0]     mem_wr;
        logic [exp_code_w-1:0] exp_code;
        logic [reg_addr_w-1:0] rd;
        mem_op_e               mem_op;
        logic [word_w-1:0]     exp_fwd;    // Also the later ex_out
        logic [word_w-1:0]     exp_addr;
        logic                  exp_taken;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic                  stall;
    logic                  flush;
    logic                  id_is_jalr;
    logic [exp_code_w-1:0] id_exp_code;
    logic [word_w-1:0]     id_pc;
    logic                  id_en;
    alu_op_e               id_alu_op;
    logic [word_w-1:0]     id_alu_in_0;
    logic [word_w-1:0]     id_alu_in_1;
    cmp_op_e               id_cmp_op;
    logic [word_w-1:0]     id_cmp_in_0;
    logic [word_w-1:0]     id_cmp_in_1;
    logic                  id_jump_taken;
    mem_op_e               id_mem_op;
    logic [word_w-1:0]     id_mem_wr_data;
    logic [reg_addr_w-1:0] id_rd_addr;
    logic                  id_gpr_we_n;
    ex_out_sel_e           id_ex_out_sel;
    logic [word_w-1:0]     id_gpr_wr_data;
    logic                  rs1_fwd_en;
    logic                  rs2_fwd_en;
    logic [word_w-1:0]     mem_fwd_data;
    logic [word_w-1:0]     fwd_data;
    logic [word_w-1:0]     br_addr;
    logic                  br_taken;
    logic [exp_code_w-1:0] ex_exp_code;
    logic [word_w-1:0]     ex_pc;
    logic                  ex_en;
    mem_op_e               ex_mem_op;
    logic [word_w-1:0]     ex_mem_wr_data;
    logic [reg_addr_w-1:0] ex_rd_addr;
    logic                  ex_gpr_we_n;
    logic [word_w-1:0]     ex_out;

    row_t tbl [n_rows];
    row_t prev;             // Row now in the EX/MEM register
    bit   prev_ok;
    int   n_tbl;
    int   errors;
    int   checks;
    int   cycles;

    ex_clk_gen u_clk_gen (.clk(clk), .rst(rst));

    ex_unit_top #(.DATA_W(word_w)) u_ex_unit_top (.*);

    //////////////////////////////
    // Table building
    //////////////////////////////
    function automatic row_t base_row(input int n);
        row_t r;
        r          = '0;                    // ADD, CMP_EQ, ALU select
        r.pc       = 32'h400 + 32'(n) * 4;
        r.mem_wr   = 32'h5555_0000 + 32'(n);
        r.exp_code = 3'(n);
        r.rd       = 5'(n);
        r.mem_op   = mem_op_e'(4'(n % 9)); // Walk all memory codes
        return r;
    endfunction

    task automatic add_row(input alu_op_e op, input logic [word_w-1:0] a0,
                           input logic [word_w-1:0] a1, input logic [word_w-1:0] res);
        row_t r;
        r          = base_row(n_tbl);
        r.op       = op;
        r.a0       = a0;
        r.a1       = a1;
        r.exp_fwd  = res;
        r.exp_addr = res;                   // Target is the raw ALU sum
        tbl[n_tbl] = r;
        n_tbl++;
    endtask

    task automatic set_sel(input ex_out_sel_e sel, input logic [word_w-1:0] link,
                           input logic [word_w-1:0] res);
        tbl[n_tbl-1].sel     = sel;
        tbl[n_tbl-1].link    = link;
        tbl[n_tbl-1].exp_fwd = res;
    endtask

    task automatic set_br(input cmp_op_e cop, input logic [word_w-1:0] c0,
                          input logic [word_w-1:0] c1, input logic we_n,
                          input logic jalr, input logic jump, input logic taken);
        tbl[n_tbl-1].cop       = cop;
        tbl[n_tbl-1].c0        = c0;
        tbl[n_tbl-1].c1        = c1;
        tbl[n_tbl-1].we_n      = we_n;
        tbl[n_tbl-1].jalr      = jalr;
        tbl[n_tbl-1].jump      = jump;
        tbl[n_tbl-1].exp_taken = taken;
    endtask

    task automatic build_table();
        add_row(ALU_ADD,   32'h5,         32'h7,         32'hc);
        add_row(ALU_SUB,   32'h5,         32'h7,         32'hffff_fffe);
        add_row(ALU_AND,   32'hf0f0_f0f0, 32'h0ff0_0ff0, 32'h00f0_00f0);
        add_row(ALU_OR,    32'hf0f0_f0f0, 32'h0ff0_0ff0, 32'hfff0_fff0);
        add_row(ALU_XOR,   32'hf0f0_f0f0, 32'h0ff0_0ff0, 32'hff00_ff00);
        add_row(ALU_SLL,   32'h1,         32'h24,        32'h10);        // Amount 4
        add_row(ALU_SRL,   32'h8000_0000, 32'h24,        32'h0800_0000);
        add_row(ALU_SRA,   32'h8000_0000, 32'h24,        32'hf800_0000); // Sign fill
        add_row(ALU_SLT,   32'hffff_ffff, 32'h1,         32'h1);
        add_row(ALU_SLTU,  32'hffff_ffff, 32'h1,         32'h0);
        add_row(ALU_PASS1, 32'h1234,      32'habcd_e000, 32'habcd_e000); // LUI
        // Compare bit written to a GPR, so never a branch
        add_row(ALU_ADD, 32'h0, 32'h0, 32'h0);
        set_sel(EX_OUT_CMP, 32'h0, 32'h1);
        set_br(CMP_EQ, 32'h3, 32'h3, 1'b0, 1'b0, 1'b0, 1'b0);
        add_row(ALU_ADD, 32'h0, 32'h0, 32'h0);
        set_sel(EX_OUT_CMP, 32'h0, 32'h0);
        set_br(CMP_NE, 32'h3, 32'h3, 1'b0, 1'b0, 1'b0, 1'b0);
        // JAL then JALR, link value out
        add_row(ALU_ADD, 32'h100, 32'h20, 32'h120);
        set_sel(EX_OUT_PCN, 32'h104, 32'h104);
        set_br(CMP_NE, 32'h0, 32'h0, 1'b0, 1'b0, 1'b1, 1'b1);
        add_row(ALU_ADD, 32'h2001, 32'h4, 32'h2005);
        set_sel(EX_OUT_PCN, 32'h208, 32'h208);
        set_br(CMP_NE, 32'h0, 32'h0, 1'b0, 1'b1, 1'b1, 1'b1);
        tbl[n_tbl-1].exp_addr = 32'h2004;  // LSB cleared
        add_row(ALU_ADD, 32'h2001, 32'h4, 32'h2005); // Odd target kept
        // Conditional branches
        add_row(ALU_ADD, 32'h400, 32'h10, 32'h410);
        set_br(CMP_EQ, 32'h7, 32'h7, 1'b1, 1'b0, 1'b0, 1'b1);
        add_row(ALU_ADD, 32'h400, 32'h10, 32'h410);
        set_br(CMP_NE, 32'h7, 32'h7, 1'b1, 1'b0, 1'b0, 1'b0);
        add_row(ALU_ADD, 32'h400, 32'h10, 32'h410);
        set_br(CMP_LT, 32'hffff_fff0, 32'h5, 1'b1, 1'b0, 1'b0, 1'b1);
        add_row(ALU_ADD, 32'h400, 32'h10, 32'h410);
        set_br(CMP_GE, 32'hffff_fff0, 32'h5, 1'b1, 1'b0, 1'b0, 1'b0);
        add_row(ALU_ADD, 32'h400, 32'h10, 32'h410);
        set_br(CMP_LTU, 32'hffff_fff0, 32'h5, 1'b1, 1'b0, 1'b0, 1'b0);
        add_row(ALU_ADD, 32'h400, 32'h10, 32'h410);
        set_br(CMP_GEU, 32'hffff_fff0, 32'h5, 1'b1, 1'b0, 1'b0, 1'b1);
        // Forwarding, operand 1 untouched
        add_row(ALU_ADD, 32'h9999, 32'h10, 32'h1010);
        tbl[n_tbl-1].f1 = 1'b1;
        add_row(ALU_ADD, 32'h3, 32'h4, 32'h7);
        tbl[n_tbl-1].f2 = 1'b1;            // Store data from MEM
        add_row(ALU_ADD, 32'h1, 32'h1, 32'h2);
        set_sel(EX_OUT_RSV, 32'h0, 32'h0); // Reserved gives zero
    endtask

    // ALU behavior as specified
    function automatic logic [word_w-1:0] ref_alu(input alu_op_e op,
                                                  input logic [word_w-1:0] a,
                                                  input logic [word_w-1:0] b);
        logic [word_w-1:0] res;
        logic [4:0]        sh;
        res = '0;
        sh  = b[4:0];
        case (op)
            ALU_ADD:   res = a + b;
            ALU_SUB:   res = a + ~b + 1;
            ALU_AND:   res = a & b;
            ALU_OR:    res = a | b;
            ALU_XOR:   res = a ^ b;
            ALU_SLL:   res = a << sh;
            ALU_SRL:   res = a >> sh;
            ALU_SRA:   res = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            ALU_SLT:   res[0] = (a[31] != b[31]) ? a[31] : (a < b); // Signs differ
            ALU_SLTU:  res[0] = a < b;
            ALU_PASS1: res = b;
            default:   res = '0;
        endcase
        return res;
    endfunction

    //////////////////////////////
    // Checking
    //////////////////////////////
    task automatic check(input string name, input logic [word_w-1:0] exp,
                         input logic [word_w-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR t=%0t %s: expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_reg(input row_t r);
        check("ex_out", r.exp_fwd, ex_out);
        check("ex_en", 1'b1, ex_en);
        check("ex_gpr_we_n", r.we_n, ex_gpr_we_n);
        check("ex_mem_op", r.mem_op, ex_mem_op);
        check("ex_pc", r.pc, ex_pc);
        check("ex_exp_code", r.exp_code, ex_exp_code);
        check("ex_rd_addr", r.rd, ex_rd_addr);
        check("ex_mem_wr_data", r.f2 ? fwd_val : r.mem_wr, ex_mem_wr_data);
    endtask

    task automatic check_bubble();
        check("ex_en", 1'b0, ex_en);
        check("ex_gpr_we_n", 1'b1, ex_gpr_we_n);
        check("ex_mem_op", MEM_NOP, ex_mem_op);
        check("ex_out", '0, ex_out);            // Data cleared too
    endtask

    task automatic drive(input row_t r);
        id_is_jalr     = r.jalr;
        id_exp_code    = r.exp_code;
        id_pc          = r.pc;
        id_en          = 1'b1;
        id_alu_op      = r.op;
        id_alu_in_0    = r.a0;
        id_alu_in_1    = r.a1;
        id_cmp_op      = r.cop;
        id_cmp_in_0    = r.c0;
        id_cmp_in_1    = r.c1;
        id_jump_taken  = r.jump;
        id_mem_op      = r.mem_op;
        id_mem_wr_data = r.mem_wr;
        id_rd_addr     = r.rd;
        id_gpr_we_n    = r.we_n;
        id_ex_out_sel  = r.sel;
        id_gpr_wr_data = r.link;
        rs1_fwd_en     = r.f1;
        rs2_fwd_en     = r.f2;
    endtask

    // One issue cycle; registered check of the row before
    task automatic run_row(input row_t r);
        @(negedge clk);
        if (prev_ok)
            check_reg(prev);
        drive(r);
        #2;                                     // Comb paths settled
        check("fwd_data", r.exp_fwd, fwd_data);
        check("br_addr", r.exp_addr, br_addr);
        check("br_taken", r.exp_taken, br_taken);
        prev    = r;
        prev_ok = 1'b1;
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        row_t r;
        errors  = 0;
        checks  = 0;
        n_tbl   = 0;
        prev_ok = 1'b0;
        void'($urandom(32'h26e61457));
        stall        = 1'b0;
        flush        = 1'b0;
        mem_fwd_data = fwd_val;
        build_table();
        drive(tbl[1]);                          // Reset has to override this instruction

        @(negedge rst);
        check_bubble();                         // Reset values

        for (int i = 0; i < n_tbl; i++)
            run_row(tbl[i]);

        // Stall holds, stall beats flush, then flush alone
        @(negedge clk);
        check_reg(prev);
        stall = 1'b1;
        drive(tbl[17]);                         // Differs from the held row in every field
        id_en = 1'b0;
        @(negedge clk);
        check_reg(prev);
        flush = 1'b1;
        @(negedge clk);
        check_reg(prev);
        stall = 1'b0;
        drive(tbl[1]);                          // Valid load with GPR write
        @(negedge clk);
        check_bubble();
        flush   = 1'b0;
        prev_ok = 1'b0;

        // Random ALU traffic, undefined codes included
        for (int k = 0; k < n_rand; k++) begin
            r          = base_row(n_rows + k);
            r.op       = alu_op_e'(4'($urandom_range(15, 0)));
            r.a0       = $urandom;
            r.a1       = $urandom;
            r.mem_wr   = $urandom;
            r.f2       = 1'($urandom_range(1, 0));
            r.exp_fwd  = ref_alu(r.op, r.a0, r.a1);
            r.exp_addr = r.exp_fwd;
            run_row(r);
        end
        @(negedge clk);
        check_reg(prev);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    // Hang guard
    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", max_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule
